//--- csr.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_write_decode.sv
verilog/csr_mode_regs.sv
verilog/csr_timer.sv
verilog/csr_llbit_save.sv
verilog/csr_read_mux.sv
verilog/csr_top.sv
sim/tb_csr.sv

//--- Makefile
TOP := tb_csr
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(OBJ)/V$(TOP): csr.f verilog/*.sv verilog/*.svh sim/*.sv
	verilator --binary --timing -Wno-fatal -f csr.f --top-module $(TOP) -Mdir $(OBJ)

test: $(OBJ)/V$(TOP)
	@out=$$(./$(OBJ)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(OBJ)

//--- sim/tb_csr.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module tb_csr;

    localparam logic [3:0] k_write      = 4'd0;
    localparam logic [3:0] k_write_both = 4'd1;
    localparam logic [3:0] k_read       = 4'd2;
    localparam logic [3:0] k_excp       = 4'd3;
    localparam logic [3:0] k_ertn       = 4'd4;
    localparam logic [3:0] k_hwi        = 4'd5;
    localparam logic [3:0] k_llset      = 4'd6;
    localparam logic [3:0] k_timer_wait = 4'd7;
    localparam logic [3:0] k_count      = 4'd8;
    localparam logic [3:0] k_int        = 4'd9;
    localparam logic [3:0] k_llbit      = 4'd10;
    localparam logic [3:0] k_plv        = 4'd11;

    typedef struct packed {
        logic [3:0]             kind;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`CSR_DATA_W-1:0] data;
        logic [`CSR_DATA_W-1:0] want;
    } step_t;

    logic                     clk = 1'b0;
    logic                     rst;
    csr_pkg::csr_write_t      wr1;
    csr_pkg::csr_write_t      wr2;
    csr_pkg::excp_t           excp;
    logic [`CSR_HWI_W-1:0]    hwi;
    logic                     llbit_in;
    logic                     llbit_set;
    csr_pkg::csr_addr_e       raddr;
    logic [`CSR_DATA_W-1:0]   rdata;
    logic                     has_int;
    logic [1:0]               plv;
    logic [`CSR_DATA_W-1:0]   eentry;
    logic [`CSR_DATA_W-1:0]   era;
    logic [`CSR_DATA_W-1:0]   tid;
    logic [`CSR_STABLE_W-1:0] timer_64;
    logic                     llbit;

    step_t                  steps[$];
    logic                   table_ready;
    logic [31:0]            lfsr_state = 32'hf6227922;
    logic [`CSR_DATA_W-1:0] cntc_now;

    csr_top csr_top_inst (
        .clk         (clk),
        .rst         (rst),
        .wr1_i       (wr1),
        .wr2_i       (wr2),
        .excp_i      (excp),
        .hwi_i       (hwi),
        .llbit_i     (llbit_in),
        .llbit_set_i (llbit_set),
        .raddr_i     (raddr),
        .rdata_o     (rdata),
        .has_int_o   (has_int),
        .plv_o       (plv),
        .eentry_o    (eentry),
        .era_o       (era),
        .tid_o       (tid),
        .timer_64_o  (timer_64),
        .llbit_o     (llbit)
    );

    always #4 clk = ~clk;

    // galois form, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        return out;
    endfunction

    function automatic logic [31:0] lfsr_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++)
            w = {w[30:0], lfsr_bit()};
        return w;
    endfunction

    function automatic logic [`CSR_STABLE_W-1:0] sext64(input logic [`CSR_DATA_W-1:0] v);
        return {{(`CSR_STABLE_W - `CSR_DATA_W){v[`CSR_DATA_W-1]}}, v};
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at %0t ns", $time);
    endtask

    task automatic check_word(input string name, input logic [`CSR_DATA_W-1:0] got,
                              input logic [`CSR_DATA_W-1:0] want);
        if (got !== want)
            abort_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
                                $time, name, got, want));
    endtask

    task automatic check_plv(input string name, input logic [1:0] got, input logic [1:0] want);
        if (got !== want)
            abort_run($sformatf("mismatch at %0t ns: %s got %0d expected %0d",
                                $time, name, got, want));
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want)
            abort_run($sformatf("mismatch at %0t ns: %s got %b expected %b",
                                $time, name, got, want));
    endtask

    task automatic check_count(input string name, input logic [`CSR_STABLE_W-1:0] got,
                               input logic [`CSR_STABLE_W-1:0] want);
        if (got !== want)
            abort_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
                                $time, name, got, want));
    endtask

    task automatic add_step(input logic [3:0] kind, input logic [`CSR_ADDR_W-1:0] addr,
                            input logic [`CSR_DATA_W-1:0] data,
                            input logic [`CSR_DATA_W-1:0] want);
        steps.push_back('{kind, addr, data, want});
    endtask

    task automatic build_table();
        logic [31:0] save_w [4];
        logic [31:0] a;
        logic [31:0] b;
        logic [5:0]  ecode;
        logic [8:0]  esub;
        logic [31:0] estat_exc;
        ecode = 6'h0b;
        esub = 9'h055;
        // ecode at 21:16, esubcode at 30:22
        estat_exc = {1'b0, esub, ecode, 16'd0};

        add_step(k_read, csr_pkg::CSR_CRMD, 0, 32'h8);
        add_step(k_read, csr_pkg::CSR_PRMD, 0, 0);
        add_step(k_read, csr_pkg::CSR_ESTAT, 0, 0);
        add_step(k_read, csr_pkg::CSR_ECTL, 0, 0);
        for (int i = 0; i < 4; i++)
            add_step(k_read, 14'(csr_pkg::CSR_SAVE0) + 14'(i), 0, 0);
        add_step(k_read, csr_pkg::CSR_LLBCTL, 0, 0);
        add_step(k_read, csr_pkg::CSR_TID, 0, 0);
        add_step(k_int, 0, 0, 0);
        add_step(k_llbit, 0, 0, 0);
        add_step(k_plv, 0, 0, 0);

        for (int i = 0; i < 4; i++) begin
            save_w[i] = lfsr_word();
            add_step(k_write, 14'(csr_pkg::CSR_SAVE0) + 14'(i), save_w[i], 0);
        end
        for (int i = 0; i < 4; i++)
            add_step(k_read, 14'(csr_pkg::CSR_SAVE0) + 14'(i), 0, save_w[i]);
        add_step(k_write, csr_pkg::CSR_EENTRY, 32'h1234_567f, 0);
        add_step(k_read, csr_pkg::CSR_EENTRY, 0, 32'h1234_567f & ~32'h3f);
        add_step(k_write, csr_pkg::CSR_CRMD, 32'ha5a5_a1f0, 0);
        add_step(k_read, csr_pkg::CSR_CRMD, 0, 32'ha5a5_a1f0 & 32'h1ff);
        add_step(k_read, 14'h123, 0, 0);
        add_step(k_read, csr_pkg::CSR_TICLR, 0, 0);
        a = lfsr_word();
        b = lfsr_word();
        add_step(k_write_both, csr_pkg::CSR_SAVE0, a, b);
        add_step(k_read, csr_pkg::CSR_SAVE0, 0, a);

        // plv 3, ie set, da set
        add_step(k_write, csr_pkg::CSR_CRMD, 32'hf, 0);
        add_step(k_plv, 0, 0, 3);
        add_step(k_excp, 0, {17'd0, esub, ecode}, 32'h1c00_0040);
        add_step(k_read, csr_pkg::CSR_CRMD, 0, 32'h8);
        add_step(k_read, csr_pkg::CSR_PRMD, 0, 32'h7);
        add_step(k_read, csr_pkg::CSR_ESTAT, 0, estat_exc);
        add_step(k_read, csr_pkg::CSR_ERA, 0, 32'h1c00_0040);
        add_step(k_ertn, 0, 0, 3);
        add_step(k_read, csr_pkg::CSR_CRMD, 0, 32'hf);

        add_step(k_write, csr_pkg::CSR_ESTAT, 32'h1, 0);
        add_step(k_write, csr_pkg::CSR_ECTL, 32'h1, 0);
        add_step(k_int, 0, 0, 1);
        add_step(k_write, csr_pkg::CSR_ECTL, 32'h0, 0);
        add_step(k_int, 0, 0, 0);
        add_step(k_write, csr_pkg::CSR_ECTL, 32'h1, 0);
        add_step(k_int, 0, 0, 1);
        add_step(k_write, csr_pkg::CSR_ESTAT, 32'h0, 0);
        add_step(k_int, 0, 0, 0);
        add_step(k_write, csr_pkg::CSR_ESTAT, 32'h1, 0);
        add_step(k_int, 0, 0, 1);
        add_step(k_write, csr_pkg::CSR_CRMD, 32'h8, 0);
        add_step(k_int, 0, 0, 0);
        add_step(k_write, csr_pkg::CSR_ESTAT, 32'h0, 0);
        add_step(k_write, csr_pkg::CSR_ECTL, 32'h0, 0);
        // hw lines land in is 10:2 one cycle late
        add_step(k_hwi, 0, 32'h1a5, estat_exc);
        add_step(k_read, csr_pkg::CSR_ESTAT, 0, estat_exc | (32'h1a5 << 2));
        add_step(k_hwi, 0, 32'h0, estat_exc | (32'h1a5 << 2));
        add_step(k_read, csr_pkg::CSR_ESTAT, 0, estat_exc);

        // one-shot, initval 2
        add_step(k_write, csr_pkg::CSR_ECTL, 32'h800, 0);
        add_step(k_write, csr_pkg::CSR_TCFG, (32'd2 << 2) | 32'h1, 0);
        add_step(k_timer_wait, 0, 2 * 4 + 4, 0);
        add_step(k_read, csr_pkg::CSR_ESTAT, 0, estat_exc | 32'h800);
        add_step(k_write, csr_pkg::CSR_TICLR, 32'h1, 0);
        add_step(k_read, csr_pkg::CSR_ESTAT, 0, estat_exc);
        add_step(k_write, csr_pkg::CSR_ECTL, 32'h0, 0);
        add_step(k_write, csr_pkg::CSR_TID, 32'h5a5a_0001, 0);
        add_step(k_read, csr_pkg::CSR_TID, 0, 32'h5a5a_0001);
        add_step(k_count, 0, 17, 0);
        add_step(k_count, csr_pkg::CSR_CNTC, 10, 32'hffff_fff0);

        add_step(k_llset, 0, 1, 0);
        add_step(k_llbit, 0, 0, 1);
        add_step(k_ertn, 0, 0, 3);
        add_step(k_llbit, 0, 0, 0);
        add_step(k_llset, 0, 1, 0);
        add_step(k_write, csr_pkg::CSR_LLBCTL, 32'h4, 0);
        add_step(k_read, csr_pkg::CSR_LLBCTL, 0, 32'h5);
        add_step(k_ertn, 0, 0, 3);
        add_step(k_llbit, 0, 0, 1);
        add_step(k_read, csr_pkg::CSR_LLBCTL, 0, 32'h1);
        add_step(k_write, csr_pkg::CSR_LLBCTL, 32'h2, 0);
        add_step(k_llbit, 0, 0, 0);
    endtask

    // every step starts and ends on a falling edge
    task automatic run_step(input step_t s);
        logic [`CSR_STABLE_W-1:0] t0;
        logic [`CSR_STABLE_W-1:0] t1;
        logic [`CSR_STABLE_W-1:0] want_diff;
        logic                     hit;
        int                       n;
        hit = 1'b0;
        n = 0;
        case (s.kind)
            k_write: begin
                wr1 = '{1'b1, s.addr, s.data};
                @(negedge clk);
                wr1 = '0;
            end
            k_write_both: begin
                wr1 = '{1'b1, s.addr, s.data};
                wr2 = '{1'b1, s.addr, s.want};
                @(negedge clk);
                wr1 = '0;
                wr2 = '0;
            end
            k_read: begin
                raddr = csr_pkg::csr_addr_e'(s.addr);
                #1;
                check_word($sformatf("rdata_o (addr %h)", s.addr), rdata, s.want);
                // these registers also have their own output ports
                if (s.addr == 14'(csr_pkg::CSR_EENTRY))
                    check_word("eentry_o", eentry, s.want);
                if (s.addr == 14'(csr_pkg::CSR_ERA))
                    check_word("era_o", era, s.want);
                if (s.addr == 14'(csr_pkg::CSR_TID))
                    check_word("tid_o", tid, s.want);
                @(negedge clk);
            end
            k_excp: begin
                excp.excp_flush = 1'b1;
                excp.ecode = s.data[5:0];
                excp.esubcode = s.data[14:6];
                excp.era = s.want;
                #1;
                check_plv("plv_o", plv, 2'd0);
                @(negedge clk);
                excp = '0;
            end
            k_ertn: begin
                excp.ertn_flush = 1'b1;
                #1;
                check_plv("plv_o", plv, s.want[1:0]);
                @(negedge clk);
                excp = '0;
            end
            k_hwi: begin
                hwi = s.data[`CSR_HWI_W-1:0];
                raddr = csr_pkg::CSR_ESTAT;
                #1;
                check_word("rdata_o (estat)", rdata, s.want);
                @(negedge clk);
            end
            k_llset: begin
                llbit_set = 1'b1;
                llbit_in = s.data[0];
                @(negedge clk);
                llbit_set = 1'b0;
                llbit_in = 1'b0;
            end
            k_timer_wait: begin
                raddr = csr_pkg::CSR_ESTAT;
                while (!hit && n <= int'(s.data)) begin
                    #1;
                    hit = rdata[11];
                    n++;
                    @(negedge clk);
                end
                if (!hit)
                    abort_run($sformatf("timer interrupt not seen in estat within %0d cycles",
                                        s.data));
            end
            k_count: begin
                t0 = timer_64;
                want_diff = 64'(s.data);
                if (s.addr == 14'(csr_pkg::CSR_CNTC)) begin
                    wr1 = '{1'b1, s.addr, s.want};
                    want_diff = want_diff + sext64(s.want) - sext64(cntc_now);
                    cntc_now = s.want;
                end
                @(negedge clk);
                wr1 = '0;
                repeat (s.data - 1) @(negedge clk);
                t1 = timer_64;
                check_count("timer_64_o delta", t1 - t0, want_diff);
            end
            k_int: begin
                #1;
                check_bit("has_int_o", has_int, s.want[0]);
                @(negedge clk);
            end
            k_llbit: begin
                #1;
                check_bit("llbit_o", llbit, s.want[0]);
                @(negedge clk);
            end
            k_plv: begin
                #1;
                check_plv("plv_o", plv, s.want[1:0]);
                @(negedge clk);
            end
            default: abort_run($sformatf("unknown step kind %0d in the table", s.kind));
        endcase
    endtask

    initial begin
        rst = 1'b1;
        wr1 = '0;
        wr2 = '0;
        excp = '0;
        hwi = '0;
        llbit_in = 1'b0;
        llbit_set = 1'b0;
        raddr = csr_pkg::CSR_CRMD;
        cntc_now = '0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        foreach (steps[i])
            run_step(steps[i]);
        $display("TEST OK");
        $finish;
    end

    // 40 cycles of 8 ns per step
    initial begin
        wait (table_ready === 1'b1);
        #(steps.size() * 40 * 8);
        abort_run("timeout: the step table did not finish in time");
    end

endmodule

`default_nettype wire

//--- verilog/csr_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_top (
    input  logic                     clk,
    input  logic                     rst,
    input  csr_pkg::csr_write_t      wr1_i,
    input  csr_pkg::csr_write_t      wr2_i,
    input  csr_pkg::excp_t           excp_i,
    input  logic [`CSR_HWI_W-1:0]    hwi_i,
    input  logic                     llbit_i,
    input  logic                     llbit_set_i,
    input  csr_pkg::csr_addr_e       raddr_i,
    output logic [`CSR_DATA_W-1:0]   rdata_o,
    output logic                     has_int_o,
    output logic [1:0]               plv_o,
    output logic [`CSR_DATA_W-1:0]   eentry_o,
    output logic [`CSR_DATA_W-1:0]   era_o,
    output logic [`CSR_DATA_W-1:0]   tid_o,
    output logic [`CSR_STABLE_W-1:0] timer_64_o,
    output logic                     llbit_o
);

    csr_pkg::csr_wstrobe_t  wstrobe;
    logic [`CSR_DATA_W-1:0] wdata;
    logic                   timer_int;
    csr_pkg::mode_view_t    mode_view;
    csr_pkg::timer_view_t   timer_view;
    csr_pkg::scratch_view_t scratch_view;

    csr_write_decode csr_write_decode_inst (
        .wr1_i     (wr1_i),
        .wr2_i     (wr2_i),
        .wstrobe_o (wstrobe),
        .wdata_o   (wdata)
    );

    csr_mode_regs csr_mode_regs_inst (
        .clk         (clk),
        .rst         (rst),
        .wstrobe_i   (wstrobe),
        .wdata_i     (wdata),
        .excp_i      (excp_i),
        .hwi_i       (hwi_i),
        .timer_int_i (timer_int),
        .view_o      (mode_view),
        .has_int_o   (has_int_o),
        .plv_o       (plv_o),
        .eentry_o    (eentry_o),
        .era_o       (era_o)
    );

    csr_timer csr_timer_inst (
        .clk         (clk),
        .rst         (rst),
        .wstrobe_i   (wstrobe),
        .wdata_i     (wdata),
        .view_o      (timer_view),
        .timer_int_o (timer_int),
        .tid_o       (tid_o),
        .timer_64_o  (timer_64_o)
    );

    csr_llbit_save csr_llbit_save_inst (
        .clk         (clk),
        .rst         (rst),
        .wstrobe_i   (wstrobe),
        .wdata_i     (wdata),
        .ertn_i      (excp_i.ertn_flush),
        .llbit_i     (llbit_i),
        .llbit_set_i (llbit_set_i),
        .view_o      (scratch_view),
        .llbit_o     (llbit_o)
    );

    csr_read_mux csr_read_mux_inst (
        .raddr_i   (raddr_i),
        .mode_i    (mode_view),
        .timer_i   (timer_view),
        .scratch_i (scratch_view),
        .rdata_o   (rdata_o)
    );

endmodule

`default_nettype wire

//--- verilog/csr_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_read_mux (
    input  csr_pkg::csr_addr_e     raddr_i,
    input  csr_pkg::mode_view_t    mode_i,
    input  csr_pkg::timer_view_t   timer_i,
    input  csr_pkg::scratch_view_t scratch_i,
    output logic [`CSR_DATA_W-1:0] rdata_o
);

    always_comb begin
        case (raddr_i)
            csr_pkg::CSR_CRMD:   rdata_o = mode_i.crmd;
            csr_pkg::CSR_PRMD:   rdata_o = mode_i.prmd;
            csr_pkg::CSR_ECTL:   rdata_o = mode_i.ectl;
            csr_pkg::CSR_ESTAT:  rdata_o = mode_i.estat;
            csr_pkg::CSR_ERA:    rdata_o = mode_i.era;
            csr_pkg::CSR_EENTRY: rdata_o = mode_i.eentry;
            csr_pkg::CSR_SAVE0:  rdata_o = scratch_i.save[0];
            csr_pkg::CSR_SAVE1:  rdata_o = scratch_i.save[1];
            csr_pkg::CSR_SAVE2:  rdata_o = scratch_i.save[2];
            csr_pkg::CSR_SAVE3:  rdata_o = scratch_i.save[3];
            csr_pkg::CSR_TID:    rdata_o = timer_i.tid;
            csr_pkg::CSR_TCFG:   rdata_o = timer_i.tcfg;
            csr_pkg::CSR_TVAL:   rdata_o = timer_i.tval;
            csr_pkg::CSR_CNTC:   rdata_o = timer_i.cntc;
            csr_pkg::CSR_LLBCTL: rdata_o = scratch_i.llbctl;
            // ticlr is write-only
            csr_pkg::CSR_TICLR:  rdata_o = '0;
            default:             rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/csr_llbit_save.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_llbit_save (
    input  logic                   clk,
    input  logic                   rst,
    input  csr_pkg::csr_wstrobe_t  wstrobe_i,
    input  logic [`CSR_DATA_W-1:0] wdata_i,
    input  logic                   ertn_i,
    input  logic                   llbit_i,
    input  logic                   llbit_set_i,
    output csr_pkg::scratch_view_t view_o,
    output logic                   llbit_o
);

    logic [`CSR_SAVE_N-1:0][`CSR_DATA_W-1:0] save;
    logic                                    klo;
    logic                                    llbit;

    always_ff @(posedge clk) begin
        for (int i = 0; i < `CSR_SAVE_N; i++) begin
            if (rst)
                save[i] <= '0;
            else if (wstrobe_i.save[i])
                save[i] <= wdata_i;
        end
    end

    // klo shields the ll bit from one ertn
    always_ff @(posedge clk) begin
        if (rst) begin
            klo   <= 1'b0;
            llbit <= 1'b0;
        end else if (ertn_i) begin
            if (klo)
                klo <= 1'b0;
            else
                llbit <= 1'b0;
        end else if (wstrobe_i.llbctl) begin
            klo <= wdata_i[`CSR_LLB_KLO];
            if (wdata_i[`CSR_LLB_WCLLB])
                llbit <= 1'b0;
        end else if (llbit_set_i) begin
            llbit <= llbit_i;
        end
    end

    assign llbit_o       = llbit;
    assign view_o.save   = save;
    assign view_o.llbctl = {29'd0, klo, 1'b0, llbit};

endmodule

`default_nettype wire

//--- verilog/csr_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_timer (
    input  logic                     clk,
    input  logic                     rst,
    input  csr_pkg::csr_wstrobe_t    wstrobe_i,
    input  logic [`CSR_DATA_W-1:0]   wdata_i,
    output csr_pkg::timer_view_t     view_o,
    output logic                     timer_int_o,
    output logic [`CSR_DATA_W-1:0]   tid_o,
    output logic [`CSR_STABLE_W-1:0] timer_64_o
);

    logic [`CSR_DATA_W-1:0]   tid;
    csr_pkg::tcfg_t           tcfg;
    logic [`CSR_DATA_W-1:0]   tval;
    logic [`CSR_DATA_W-1:0]   cntc;
    logic [`CSR_STABLE_W-1:0] stable;
    logic                     timer_en;
    logic                     timer_int;
    logic                     expire;

    assign expire = timer_en && (tval == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            tid    <= '0;
            tcfg   <= '0;
            cntc   <= '0;
            stable <= '0;
        end else begin
            stable <= stable + 1'b1;
            if (wstrobe_i.tid)
                tid <= wdata_i;
            if (wstrobe_i.tcfg)
                tcfg <= csr_pkg::tcfg_t'(wdata_i);
            if (wstrobe_i.cntc)
                cntc <= wdata_i;
        end
    end

    // tcfg write restarts the count from initval*4
    always_ff @(posedge clk) begin
        if (wstrobe_i.tcfg)
            tval <= {wdata_i[`CSR_DATA_W-1:2], 2'b00};
        else if (wstrobe_i.tval)
            tval <= wdata_i;
        else if (expire)
            tval <= tcfg.periodic ? {tcfg.initval, 2'b00} : '1;
        else if (timer_en)
            tval <= tval - 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            timer_en  <= 1'b0;
            timer_int <= 1'b0;
        end else begin
            if (wstrobe_i.tcfg)
                timer_en <= wdata_i[0];
            else if (expire)
                timer_en <= tcfg.periodic;
            if (wstrobe_i.ticlr && wdata_i[`CSR_TICLR_CLR])
                timer_int <= 1'b0;
            else if (expire && !wstrobe_i.tcfg)
                timer_int <= 1'b1;
        end
    end

    assign timer_int_o = timer_int;
    assign tid_o       = tid;
    assign timer_64_o  = stable
        + {{(`CSR_STABLE_W - `CSR_DATA_W){cntc[`CSR_DATA_W-1]}}, cntc};

    assign view_o = '{tid: tid, tcfg: tcfg, tval: tval, cntc: cntc};

endmodule

`default_nettype wire

//--- verilog/csr_mode_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_mode_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  csr_pkg::csr_wstrobe_t  wstrobe_i,
    input  logic [`CSR_DATA_W-1:0] wdata_i,
    input  csr_pkg::excp_t         excp_i,
    input  logic [`CSR_HWI_W-1:0]  hwi_i,
    input  logic                   timer_int_i,
    output csr_pkg::mode_view_t    view_o,
    output logic                   has_int_o,
    output logic [1:0]             plv_o,
    output logic [`CSR_DATA_W-1:0] eentry_o,
    output logic [`CSR_DATA_W-1:0] era_o
);

    csr_pkg::crmd_t          crmd;
    csr_pkg::prmd_t          prmd;
    logic [`CSR_IS_W-1:0]    lie;
    logic [1:0]              is_sw;
    logic [`CSR_HWI_W-1:0]   is_hw;
    logic [`CSR_IS_W-1:0]    is_all;
    logic [`CSR_ECODE_W-1:0] ecode;
    logic [`CSR_ESUB_W-1:0]  esubcode;
    logic [`CSR_DATA_W-1:0]  era;
    logic [`CSR_DATA_W-1:0]  eentry;

    // exception entry beats return, both beat software
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd <= csr_pkg::crmd_t'(`CSR_CRMD_RST);
            prmd <= '0;
        end else if (excp_i.excp_flush) begin
            crmd.plv <= 2'd0;
            crmd.ie  <= 1'b0;
            prmd     <= '{pie: crmd.ie, pplv: crmd.plv};
        end else if (excp_i.ertn_flush) begin
            crmd.plv <= prmd.pplv;
            crmd.ie  <= prmd.pie;
        end else begin
            if (wstrobe_i.crmd)
                crmd <= csr_pkg::crmd_t'(wdata_i[8:0]);
            if (wstrobe_i.prmd)
                prmd <= csr_pkg::prmd_t'(wdata_i[2:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lie      <= '0;
            is_sw    <= '0;
            is_hw    <= '0;
            ecode    <= '0;
            esubcode <= '0;
        end else begin
            is_hw <= hwi_i;
            if (wstrobe_i.ectl)
                lie <= wdata_i[`CSR_IS_W-1:0];
            if (wstrobe_i.estat)
                is_sw <= wdata_i[1:0];
            if (excp_i.excp_flush) begin
                ecode    <= excp_i.ecode;
                esubcode <= excp_i.esubcode;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (excp_i.excp_flush)
            era <= excp_i.era;
        else if (wstrobe_i.era)
            era <= wdata_i;
        if (wstrobe_i.eentry)
            eentry <= wdata_i & `CSR_EENTRY_MASK;
    end

    // timer pending sits at is bit 11, bit 12 unused
    assign is_all = {1'b0, timer_int_i, is_hw, is_sw};

    assign has_int_o = (|(lie & is_all)) & crmd.ie;

    always_comb begin
        if (excp_i.excp_flush)
            plv_o = 2'd0;
        else if (excp_i.ertn_flush)
            plv_o = prmd.pplv;
        else
            plv_o = crmd.plv;
    end

    assign eentry_o = eentry;
    assign era_o    = era;

    assign view_o.crmd   = {23'd0, crmd};
    assign view_o.prmd   = {29'd0, prmd};
    assign view_o.ectl   = {19'd0, lie};
    assign view_o.estat  = {1'b0, esubcode, ecode, 3'd0, is_all};
    assign view_o.era    = era;
    assign view_o.eentry = eentry;

    // the pipeline flushes for one reason at a time
    a_flush_excl: assert property (@(posedge clk) disable iff (rst)
        !(excp_i.excp_flush && excp_i.ertn_flush))
        else $error("excp_flush and ertn_flush together");

endmodule

`default_nettype wire

//--- verilog/csr_write_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_write_decode (
    input  csr_pkg::csr_write_t    wr1_i,
    input  csr_pkg::csr_write_t    wr2_i,
    output csr_pkg::csr_wstrobe_t  wstrobe_o,
    output logic [`CSR_DATA_W-1:0] wdata_o
);

    csr_pkg::csr_write_t wr;

    // port 1 wins, port 2 is dropped on a collision
    assign wr      = wr1_i.we ? wr1_i : wr2_i;
    assign wdata_o = wr.data;

    always_comb begin
        wstrobe_o = '0;
        if (wr.we) begin
            case (csr_pkg::csr_addr_e'(wr.addr))
                csr_pkg::CSR_CRMD:   wstrobe_o.crmd    = 1'b1;
                csr_pkg::CSR_PRMD:   wstrobe_o.prmd    = 1'b1;
                csr_pkg::CSR_ECTL:   wstrobe_o.ectl    = 1'b1;
                csr_pkg::CSR_ESTAT:  wstrobe_o.estat   = 1'b1;
                csr_pkg::CSR_ERA:    wstrobe_o.era     = 1'b1;
                csr_pkg::CSR_EENTRY: wstrobe_o.eentry  = 1'b1;
                csr_pkg::CSR_SAVE0:  wstrobe_o.save[0] = 1'b1;
                csr_pkg::CSR_SAVE1:  wstrobe_o.save[1] = 1'b1;
                csr_pkg::CSR_SAVE2:  wstrobe_o.save[2] = 1'b1;
                csr_pkg::CSR_SAVE3:  wstrobe_o.save[3] = 1'b1;
                csr_pkg::CSR_TID:    wstrobe_o.tid     = 1'b1;
                csr_pkg::CSR_TCFG:   wstrobe_o.tcfg    = 1'b1;
                csr_pkg::CSR_TVAL:   wstrobe_o.tval    = 1'b1;
                csr_pkg::CSR_CNTC:   wstrobe_o.cntc    = 1'b1;
                csr_pkg::CSR_TICLR:  wstrobe_o.ticlr   = 1'b1;
                csr_pkg::CSR_LLBCTL: wstrobe_o.llbctl  = 1'b1;
                default:             wstrobe_o         = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/csr_pkg.sv
`default_nettype none

`include "csr_cfg.svh"

package csr_pkg;

    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECTL   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_CNTC   = 14'h043,
        CSR_TICLR  = 14'h044,
        CSR_LLBCTL = 14'h060
    } csr_addr_e;

    typedef struct packed {
        logic                   we;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`CSR_DATA_W-1:0] data;
    } csr_write_t;

    typedef struct packed {
        logic                   crmd;
        logic                   prmd;
        logic                   ectl;
        logic                   estat;
        logic                   era;
        logic                   eentry;
        logic [`CSR_SAVE_N-1:0] save;
        logic                   tid;
        logic                   tcfg;
        logic                   tval;
        logic                   cntc;
        logic                   ticlr;
        logic                   llbctl;
    } csr_wstrobe_t;

    // msb first, so plv lands in bits 1:0
    typedef struct packed {
        logic [1:0] datm;
        logic [1:0] datf;
        logic       pg;
        logic       da;
        logic       ie;
        logic [1:0] plv;
    } crmd_t;

    typedef struct packed {
        logic       pie;
        logic [1:0] pplv;
    } prmd_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    typedef struct packed {
        logic                    excp_flush;
        logic                    ertn_flush;
        logic [`CSR_ECODE_W-1:0] ecode;
        logic [`CSR_ESUB_W-1:0]  esubcode;
        logic [`CSR_DATA_W-1:0]  era;
    } excp_t;

    typedef struct packed {
        logic [`CSR_DATA_W-1:0] crmd;
        logic [`CSR_DATA_W-1:0] prmd;
        logic [`CSR_DATA_W-1:0] ectl;
        logic [`CSR_DATA_W-1:0] estat;
        logic [`CSR_DATA_W-1:0] era;
        logic [`CSR_DATA_W-1:0] eentry;
    } mode_view_t;

    typedef struct packed {
        logic [`CSR_DATA_W-1:0] tid;
        logic [`CSR_DATA_W-1:0] tcfg;
        logic [`CSR_DATA_W-1:0] tval;
        logic [`CSR_DATA_W-1:0] cntc;
    } timer_view_t;

    typedef struct packed {
        logic [`CSR_SAVE_N-1:0][`CSR_DATA_W-1:0] save;
        logic [`CSR_DATA_W-1:0]                  llbctl;
    } scratch_view_t;

endpackage

`default_nettype wire

//--- verilog/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// bus and field widths
`define CSR_ADDR_W 14
`define CSR_DATA_W 32
`define CSR_HWI_W 9
`define CSR_IS_W 13
`define CSR_ECODE_W 6
`define CSR_ESUB_W 9
`define CSR_STABLE_W 64
`define CSR_SAVE_N 4

// crmd comes out of reset in direct address mode
`define CSR_CRMD_RST 9'h008

// eentry is 64-byte aligned
`define CSR_EENTRY_MASK 32'hffff_ffc0

// single-bit fields in write data
`define CSR_TICLR_CLR 0
`define CSR_LLB_WCLLB 1
`define CSR_LLB_KLO 2

`endif
